// File: sim.f
cdc_fifo_pkg.sv
cdc_gray_sync.sv
cdc_fifo_push_ctrl.sv
cdc_fifo_pop_ctrl.sv
cdc_fifo_ctrl.sv
cdc_fifo_ram.sv
cdc_fifo_top.sv
tb_cdc_fifo.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cdc_fifo -f sim.f

out=$(./obj_dir/Vtb_cdc_fifo) || true
echo "$out"

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1

// File: tb_cdc_fifo.sv
// CDC FIFO testbench
`default_nettype none

module tb_cdc_fifo;

  localparam int Depth = cdc_fifo_pkg::default_depth;
  localparam int Width = cdc_fifo_pkg::default_width;
  localparam int CountWidth = $clog2(Depth + 1);
  localparam int NumSends = 400;
  // Push cycles for the whole run, one per send plus margin for stalls and syncs
  localparam int CycleLimit = NumSends + 2000;

  // DUT ports
  logic                  push_clk;
  logic                  rst_n;
  logic                  push_credit_stall;
  logic                  push_credit;
  logic                  push_valid;
  logic [     Width-1:0] push_data;
  logic                  push_full;
  logic [CountWidth-1:0] push_slots;
  logic                  pop_clk;
  logic                  pop_ready;
  logic                  pop_valid;
  logic [     Width-1:0] pop_data;
  logic                  pop_empty;
  logic [CountWidth-1:0] pop_items;

  // Scoreboard of words sent but not yet popped, oldest first
  logic [Width-1:0] sb_q [$];
  logic [Width-1:0] sb_head;
  int               sb_count;

  // Run bookkeeping
  int               sent;
  int               credits_rcvd;
  int               pops_done;
  int               errors;
  int               cycles;
  int               push_rel_cnt;
  int               pop_rel_cnt;
  logic             hold_pop;
  logic             stall_prev;
  logic [Width-1:0] pop_data_prev;
  logic [Width-1:0] next_word;

  cdc_fifo_top cdc_fifo_top_inst (
      .push_clk,
      .rst_n,
      .push_credit_stall,
      .push_credit,
      .push_valid,
      .push_data,
      .push_full,
      .push_slots,
      .pop_clk,
      .pop_ready,
      .pop_valid,
      .pop_data,
      .pop_empty,
      .pop_items
  );

  // Periods of 100 and 146 never line up, so the phase keeps drifting
  always #50 push_clk = ~push_clk;
  always #73 pop_clk = ~pop_clk;

  // Head of the scoreboard as plain signals that assertions can sample
  task automatic refresh_head();
    sb_count = sb_q.size();
    sb_head  = (sb_count > 0) ? sb_q[0] : '0;
  endtask

  // --------------------------------------------------
  // Sender and receiver
  // --------------------------------------------------

  // Pushes only while a received credit is still unspent
  always @(negedge push_clk) begin
    push_valid = 1'b0;
    if (rst_n && (sent < NumSends) && (credits_rcvd > sent) && (($urandom % 4) != 0)) begin
      next_word  = Width'($urandom);
      push_valid = 1'b1;
      push_data  = next_word;
      sb_q.push_back(next_word);
      sent++;
      refresh_head();
    end
  end

  // Random back-pressure, or a full stop during the fill phase
  always @(negedge pop_clk) begin
    pop_ready = !hold_pop && (($urandom % 4) != 0);
  end

  always @(posedge push_clk) begin
    cycles <= cycles + 1;
    if (rst_n) begin
      push_rel_cnt <= push_rel_cnt + 1;
    end
    if (push_credit) begin
      credits_rcvd <= credits_rcvd + 1;
    end
  end

  always @(posedge pop_clk) begin
    pop_data_prev <= pop_data;
    stall_prev    <= rst_n && pop_valid && !pop_ready;
    if (rst_n) begin
      pop_rel_cnt <= pop_rel_cnt + 1;
    end
    if (rst_n && pop_valid && pop_ready && (sb_count > 0)) begin
      void'(sb_q.pop_front());
      pops_done++;
      refresh_head();
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Second and third edges after release, while both halves still hold reset values
  a_push_after_reset : assert property (@(posedge push_clk)
    (rst_n && (push_rel_cnt == 1 || push_rel_cnt == 2)) |->
    (!push_credit && !push_full && push_slots == CountWidth'(Depth)))
  else begin
    errors++;
    $display("** Error: after reset push_credit 0x%h push_full 0x%h push_slots 0x%h",
             $sampled(push_credit), $sampled(push_full), $sampled(push_slots));
  end

  a_pop_after_reset : assert property (@(posedge pop_clk)
    (rst_n && (pop_rel_cnt == 1 || pop_rel_cnt == 2)) |->
    (!pop_valid && pop_empty && pop_items == '0))
  else begin
    errors++;
    $display("** Error: after reset pop_valid 0x%h pop_empty 0x%h pop_items 0x%h",
             $sampled(pop_valid), $sampled(pop_empty), $sampled(pop_items));
  end

  a_pop_has_word : assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && pop_ready) |-> (sb_count > 0))
  else begin
    errors++;
    $display("A word was popped although nothing was waiting to be received");
  end

  a_pop_in_order : assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && pop_ready && sb_count > 0) |-> (pop_data == sb_head))
  else begin
    errors++;
    $display("** Error: pop_data 0x%h, expected 0x%h", $sampled(pop_data), $sampled(sb_head));
  end

  a_stall_keeps_valid : assert property (@(posedge pop_clk) disable iff (!rst_n)
    stall_prev |-> pop_valid)
  else begin
    errors++;
    $display("pop_valid dropped while the receiver was stalling");
  end

  a_stall_keeps_data : assert property (@(posedge pop_clk) disable iff (!rst_n)
    stall_prev |-> (pop_data == pop_data_prev))
  else begin
    errors++;
    $display("** Error: pop_data 0x%h during stall, expected 0x%h",
             $sampled(pop_data), $sampled(pop_data_prev));
  end

  a_no_credit_in_stall : assert property (@(posedge push_clk) disable iff (!rst_n)
    push_credit_stall |-> !push_credit)
  else begin
    errors++;
    $display("** Error: push_credit 0x%h during push_credit_stall, expected 0x0",
             $sampled(push_credit));
  end

  // Every credit beyond the first Depth must stand for a slot already freed
  a_credit_bound : assert property (@(posedge push_clk) disable iff (!rst_n)
    credits_rcvd <= Depth + pops_done)
  else begin
    errors++;
    $display("** Error: credits received 0x%h, limit 0x%h",
             $sampled(credits_rcvd), Depth + $sampled(pops_done));
  end

  a_full_means_no_credit : assert property (@(posedge push_clk) disable iff (!rst_n)
    push_full |-> (credits_rcvd == sent))
  else begin
    errors++;
    $display("** Error: sender credits 0x%h while push_full, expected 0x0",
             $sampled(credits_rcvd) - $sampled(sent));
  end

  // --------------------------------------------------
  // Run sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'hf825));
    push_clk          = 1'b0;
    pop_clk           = 1'b0;
    rst_n             = 1'b0;
    push_credit_stall = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    pop_ready         = 1'b0;
    hold_pop          = 1'b0;
    sent              = 0;
    credits_rcvd      = 0;
    pops_done         = 0;
    errors            = 0;
    cycles            = 0;
    push_rel_cnt      = 0;
    pop_rel_cnt       = 0;
    refresh_head();

    // Two pop cycles also span more than two push cycles
    repeat (2) @(negedge pop_clk);
    rst_n = 1'b1;

    // Fill phase with the receiver stopped
    wait (sent >= 100);
    hold_pop = 1'b1;
    wait (push_full);
    repeat (20) @(negedge pop_clk);
    hold_pop = 1'b0;

    // Stall burst that only delays the credit return
    wait (sent >= 250);
    @(negedge push_clk);
    push_credit_stall = 1'b1;
    repeat (40) @(negedge push_clk);
    push_credit_stall = 1'b0;

    // Drain, then let any surplus credit show up before the final count
    wait (sent == NumSends && sb_count == 0);
    wait (credits_rcvd == Depth + pops_done);
    repeat (20) @(negedge push_clk);
    @(negedge pop_clk);

    assert (credits_rcvd == Depth + pops_done)
    else begin
      errors++;
      $display("** Error: credits received 0x%h, expected 0x%h", credits_rcvd, Depth + pops_done);
    end
    assert (pop_empty)
    else begin
      errors++;
      $display("** Error: pop_empty 0x%h, expected 0x1", pop_empty);
    end

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycles >= CycleLimit);
    $display("Timeout after %0d push cycles with %0d of %0d words popped",
             cycles, pops_done, NumSends);
    $display("Checks done with %0d errors", errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tb_cdc_fifo

`default_nettype wire

// File: cdc_fifo_top.sv
// CDC FIFO top level
`default_nettype none

module cdc_fifo_top #(
    parameter int Depth = cdc_fifo_pkg::default_depth,
    parameter int Width = cdc_fifo_pkg::default_width,
    parameter int NumSyncStages = cdc_fifo_pkg::default_sync_stages,
    parameter int RamReadLatency = 1,
    localparam int AddrWidth = $clog2(Depth),
    localparam int CountWidth = $clog2(Depth + 1)
) (
    // Push domain
    input  logic                  push_clk,
    input  logic                  rst_n,
    input  logic                  push_credit_stall,
    output logic                  push_credit,
    input  logic                  push_valid,
    input  logic [     Width-1:0] push_data,
    output logic                  push_full,
    output logic [CountWidth-1:0] push_slots,
    // Pop domain
    input  logic                  pop_clk,
    input  logic                  pop_ready,
    output logic                  pop_valid,
    output logic [     Width-1:0] pop_data,
    output logic                  pop_empty,
    output logic [CountWidth-1:0] pop_items
);

  // RAM ports between the controller and the memory
  logic                 ram_wr_valid;
  logic [AddrWidth-1:0] ram_wr_addr;
  logic [    Width-1:0] ram_wr_data;
  logic                 ram_rd_addr_valid;
  logic [AddrWidth-1:0] ram_rd_addr;
  logic                 ram_rd_data_valid;
  logic [    Width-1:0] ram_rd_data;

  cdc_fifo_ctrl #(
      .Depth(Depth),
      .Width(Width),
      .NumSyncStages(NumSyncStages),
      .RamReadLatency(RamReadLatency)
  ) cdc_fifo_ctrl_inst (
      .push_clk,
      .rst_n,
      .push_credit_stall,
      .push_credit,
      .push_valid,
      .push_data,
      .push_full,
      .push_slots,
      .ram_wr_valid,
      .ram_wr_addr,
      .ram_wr_data,
      .pop_clk,
      .pop_ready,
      .pop_valid,
      .pop_data,
      .pop_empty,
      .pop_items,
      .ram_rd_addr_valid,
      .ram_rd_addr,
      .ram_rd_data_valid,
      .ram_rd_data
  );

  cdc_fifo_ram #(
      .Depth(Depth),
      .Width(Width),
      .RamReadLatency(RamReadLatency)
  ) cdc_fifo_ram_inst (
      .push_clk,
      .ram_wr_valid,
      .ram_wr_addr,
      .ram_wr_data,
      .pop_clk,
      .rst_n,
      .ram_rd_addr_valid,
      .ram_rd_addr,
      .ram_rd_data_valid,
      .ram_rd_data
  );

endmodule : cdc_fifo_top

`default_nettype wire

// File: cdc_fifo_ram.sv
// Flop-based 1R1W RAM
`default_nettype none

module cdc_fifo_ram #(
    parameter int Depth = 8,
    parameter int Width = 16,
    parameter int RamReadLatency = 1,
    localparam int AddrWidth = $clog2(Depth)
) (
    // Write port on the push clock
    input  logic                 push_clk,
    input  logic                 ram_wr_valid,
    input  logic [AddrWidth-1:0] ram_wr_addr,
    input  logic [    Width-1:0] ram_wr_data,
    // Read port on the pop clock
    input  logic                 pop_clk,
    input  logic                 rst_n,
    input  logic                 ram_rd_addr_valid,
    input  logic [AddrWidth-1:0] ram_rd_addr,
    output logic                 ram_rd_data_valid,
    output logic [    Width-1:0] ram_rd_data
);

  logic [Width-1:0] mem [Depth];

  // Write latency is one push cycle
  always_ff @(posedge push_clk) begin
    if (ram_wr_valid) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  // --------------------------------------------------
  // Read pipeline
  // --------------------------------------------------

  // Entry 0 is the raw read and entry RamReadLatency is the port output
  logic [RamReadLatency:0] valid_pipe;
  logic [     Width-1:0]   data_pipe [RamReadLatency+1];

  assign valid_pipe[0] = ram_rd_addr_valid;
  assign data_pipe[0]  = mem[ram_rd_addr];

  for (genvar i = 1; i <= RamReadLatency; i++) begin : g_rd_stage
    always_ff @(posedge pop_clk) begin
      if (!rst_n) begin
        valid_pipe[i] <= 1'b0;
      end else begin
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end

    always_ff @(posedge pop_clk) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign ram_rd_data_valid = valid_pipe[RamReadLatency];
  assign ram_rd_data       = data_pipe[RamReadLatency];

endmodule : cdc_fifo_ram

`default_nettype wire

// File: cdc_fifo_ctrl.sv
// CDC FIFO controller
`default_nettype none

module cdc_fifo_ctrl #(
    parameter int Depth = 8,
    parameter int Width = 16,
    parameter int NumSyncStages = 3,
    parameter int RamReadLatency = 1,
    localparam int AddrWidth = $clog2(Depth),
    localparam int CountWidth = $clog2(Depth + 1)
) (
    // Push domain
    input  logic                  push_clk,
    input  logic                  rst_n,
    input  logic                  push_credit_stall,
    output logic                  push_credit,
    input  logic                  push_valid,
    input  logic [     Width-1:0] push_data,
    output logic                  push_full,
    output logic [CountWidth-1:0] push_slots,
    output logic                  ram_wr_valid,
    output logic [ AddrWidth-1:0] ram_wr_addr,
    output logic [     Width-1:0] ram_wr_data,
    // Pop domain
    input  logic                  pop_clk,
    input  logic                  pop_ready,
    output logic                  pop_valid,
    output logic [     Width-1:0] pop_data,
    output logic                  pop_empty,
    output logic [CountWidth-1:0] pop_items,
    output logic                  ram_rd_addr_valid,
    output logic [ AddrWidth-1:0] ram_rd_addr,
    input  logic                  ram_rd_data_valid,
    input  logic [     Width-1:0] ram_rd_data
);

  // Each count comes from a register in its own domain
  // and is synchronized inside the half that reads it
  logic [CountWidth-1:0] push_count_gray;
  logic [CountWidth-1:0] pop_count_gray;

  cdc_fifo_push_ctrl #(
      .Depth(Depth),
      .Width(Width),
      .NumSyncStages(NumSyncStages)
  ) cdc_fifo_push_ctrl_inst (
      .push_clk,
      .rst_n,
      .push_credit_stall,
      .push_credit,
      .push_valid,
      .push_data,
      .push_full,
      .push_slots,
      .ram_wr_valid,
      .ram_wr_addr,
      .ram_wr_data,
      .pop_count_gray,
      .push_count_gray
  );

  cdc_fifo_pop_ctrl #(
      .Depth(Depth),
      .Width(Width),
      .NumSyncStages(NumSyncStages),
      .RamReadLatency(RamReadLatency)
  ) cdc_fifo_pop_ctrl_inst (
      .pop_clk,
      .rst_n,
      .pop_ready,
      .pop_valid,
      .pop_data,
      .pop_empty,
      .pop_items,
      .ram_rd_addr_valid,
      .ram_rd_addr,
      .ram_rd_data_valid,
      .ram_rd_data,
      .push_count_gray,
      .pop_count_gray
  );

endmodule : cdc_fifo_ctrl

`default_nettype wire

// File: cdc_fifo_pop_ctrl.sv
// CDC FIFO pop controller
`default_nettype none

module cdc_fifo_pop_ctrl #(
    parameter int Depth = 8,
    parameter int Width = 16,
    parameter int NumSyncStages = 3,
    parameter int RamReadLatency = 1,
    localparam int AddrWidth = $clog2(Depth),
    localparam int CountWidth = $clog2(Depth + 1)
) (
    input  logic                  pop_clk,
    input  logic                  rst_n,
    // Ready and valid interface toward the receiver
    input  logic                  pop_ready,
    output logic                  pop_valid,
    output logic [     Width-1:0] pop_data,
    // Status seen from the pop side
    output logic                  pop_empty,
    output logic [CountWidth-1:0] pop_items,
    // RAM read port
    output logic                  ram_rd_addr_valid,
    output logic [ AddrWidth-1:0] ram_rd_addr,
    input  logic                  ram_rd_data_valid,
    input  logic [     Width-1:0] ram_rd_data,
    // Gray counts crossing between the halves
    input  logic [CountWidth-1:0] push_count_gray,
    output logic [CountWidth-1:0] pop_count_gray
);

  // --------------------------------------------------
  // Reset synchronizer
  // --------------------------------------------------

  logic [1:0] rst_pipe;
  logic       rst_sync_n;

  always_ff @(posedge pop_clk) begin
    rst_pipe <= {rst_pipe[0], rst_n};
  end

  assign rst_sync_n = rst_pipe[1];

  // --------------------------------------------------
  // Push count from the other domain
  // --------------------------------------------------

  logic [CountWidth-1:0] push_count_gray_sync;
  logic [CountWidth-1:0] push_count_sync;

  cdc_gray_sync #(
      .Depth(Depth),
      .NumSyncStages(NumSyncStages)
  ) cdc_gray_sync_inst (
      .clk(pop_clk),
      .rst_n(rst_sync_n),
      .gray_in(push_count_gray),
      .gray_out(push_count_gray_sync)
  );

  assign push_count_sync = CountWidth'(cdc_fifo_pkg::gray_to_bin(32'(push_count_gray_sync)));

  // --------------------------------------------------
  // Read issue and pop counting
  // --------------------------------------------------

  logic [CountWidth-1:0] pop_count;
  logic [CountWidth-1:0] pop_count_next;
  logic [CountWidth-1:0] rd_count;
  logic                  has_unread;
  logic                  rd_issue;
  logic                  rd_advance;
  logic                  pop_hs;

  assign pop_hs         = pop_valid && pop_ready;
  assign pop_count_next = pop_count + 1'b1;

  // Items include a word waiting on the RAM or parked in the staging buffer
  assign pop_items = push_count_sync - pop_count;
  assign pop_empty = (pop_items == '0);

  // Words are read strictly in order from the rd_count slot
  assign has_unread        = (rd_count != push_count_sync);
  assign ram_rd_addr_valid = rd_issue;
  assign ram_rd_addr       = rd_count[AddrWidth-1:0];

  always_ff @(posedge pop_clk) begin
    if (!rst_sync_n) begin
      pop_count      <= '0;
      pop_count_gray <= '0;
      rd_count       <= '0;
    end else begin
      if (pop_hs) begin
        pop_count      <= pop_count_next;
        pop_count_gray <= CountWidth'(cdc_fifo_pkg::bin_to_gray(32'(pop_count_next)));
      end
      if (rd_advance) begin
        rd_count <= rd_count + 1'b1;
      end
    end
  end

  if (RamReadLatency == 0) begin : g_direct
    // The read repeats every cycle until the receiver takes the word
    assign rd_issue   = has_unread;
    assign rd_advance = pop_hs;
    assign pop_valid  = ram_rd_data_valid;
    assign pop_data   = ram_rd_data;
  end else begin : g_staged
    // --------------------------------------------------
    // Staging buffer for a RAM with read latency
    // --------------------------------------------------

    cdc_fifo_pkg::stage_state_e stage_state;
    logic [Width-1:0]           stage_data;

    // A new read may go out in the cycle the staged word leaves
    assign rd_issue = has_unread &&
        ((stage_state == cdc_fifo_pkg::STAGE_EMPTY) ||
         ((stage_state == cdc_fifo_pkg::STAGE_FULL) && pop_ready));
    assign rd_advance = rd_issue;
    assign pop_valid  = (stage_state == cdc_fifo_pkg::STAGE_FULL);
    assign pop_data   = stage_data;

    always_ff @(posedge pop_clk) begin
      if (!rst_sync_n) begin
        stage_state <= cdc_fifo_pkg::STAGE_EMPTY;
      end else begin
        unique case (stage_state)
          cdc_fifo_pkg::STAGE_EMPTY: begin
            if (rd_issue) begin
              stage_state <= cdc_fifo_pkg::STAGE_WAIT_RAM;
            end
          end
          cdc_fifo_pkg::STAGE_WAIT_RAM: begin
            if (ram_rd_data_valid) begin
              stage_state <= cdc_fifo_pkg::STAGE_FULL;
            end
          end
          cdc_fifo_pkg::STAGE_FULL: begin
            // Here pop_valid is high, so pop_ready completes the handshake
            if (pop_ready) begin
              stage_state <= rd_issue ? cdc_fifo_pkg::STAGE_WAIT_RAM
                                      : cdc_fifo_pkg::STAGE_EMPTY;
            end
          end
          default: stage_state <= cdc_fifo_pkg::STAGE_EMPTY;
        endcase
      end
    end

    always_ff @(posedge pop_clk) begin
      if (ram_rd_data_valid) begin
        stage_data <= ram_rd_data;
      end
    end

    // Read data only comes back for the single read in flight
    a_data_in_wait : assert property (@(posedge pop_clk) disable iff (!rst_sync_n)
      ram_rd_data_valid |-> (stage_state == cdc_fifo_pkg::STAGE_WAIT_RAM));

    // The RAM answers exactly RamReadLatency cycles after the read
    a_read_latency : assert property (@(posedge pop_clk) disable iff (!rst_sync_n)
      ram_rd_addr_valid |-> ##RamReadLatency ram_rd_data_valid);
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  a_stalled_pop_holds : assert property (@(posedge pop_clk) disable iff (!rst_sync_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)));

endmodule : cdc_fifo_pop_ctrl

`default_nettype wire

// File: cdc_fifo_push_ctrl.sv
// CDC FIFO push controller
`default_nettype none

module cdc_fifo_push_ctrl #(
    parameter int Depth = 8,
    parameter int Width = 16,
    parameter int NumSyncStages = 3,
    localparam int AddrWidth = $clog2(Depth),
    localparam int CountWidth = $clog2(Depth + 1)
) (
    input  logic                  push_clk,
    input  logic                  rst_n,
    // Credit and valid interface toward the sender
    input  logic                  push_credit_stall,
    output logic                  push_credit,
    input  logic                  push_valid,
    input  logic [     Width-1:0] push_data,
    // Status seen from the push side
    output logic                  push_full,
    output logic [CountWidth-1:0] push_slots,
    // RAM write port
    output logic                  ram_wr_valid,
    output logic [ AddrWidth-1:0] ram_wr_addr,
    output logic [     Width-1:0] ram_wr_data,
    // Gray counts crossing between the halves
    input  logic [CountWidth-1:0] pop_count_gray,
    output logic [CountWidth-1:0] push_count_gray
);

  // --------------------------------------------------
  // Reset synchronizer
  // --------------------------------------------------

  logic [1:0] rst_pipe;
  logic       rst_sync_n;

  always_ff @(posedge push_clk) begin
    rst_pipe <= {rst_pipe[0], rst_n};
  end

  assign rst_sync_n = rst_pipe[1];

  // --------------------------------------------------
  // Pop count from the other domain
  // --------------------------------------------------

  logic [CountWidth-1:0] pop_count_gray_sync;
  logic [CountWidth-1:0] pop_count_sync;
  logic [CountWidth-1:0] pop_count_seen;
  logic [CountWidth-1:0] slots_freed;

  cdc_gray_sync #(
      .Depth(Depth),
      .NumSyncStages(NumSyncStages)
  ) cdc_gray_sync_inst (
      .clk(push_clk),
      .rst_n(rst_sync_n),
      .gray_in(pop_count_gray),
      .gray_out(pop_count_gray_sync)
  );

  assign pop_count_sync = CountWidth'(cdc_fifo_pkg::gray_to_bin(32'(pop_count_gray_sync)));
  // The synchronized count may jump by more than one if pops outpace this clock
  assign slots_freed = pop_count_sync - pop_count_seen;

  // --------------------------------------------------
  // Write side and credit return
  // --------------------------------------------------

  logic [CountWidth-1:0] push_count;
  logic [CountWidth-1:0] credit_pend;
  logic [CountWidth-1:0] credit_out;
  logic                  credit_active;

  // The RAM takes the word in the same cycle as push_valid
  assign ram_wr_valid = push_valid;
  assign ram_wr_addr  = push_count[AddrWidth-1:0];
  assign ram_wr_data  = push_data;

  // Counts wrap at twice Depth, so the difference stays between 0 and Depth
  assign push_slots = CountWidth'(Depth) - (push_count - pop_count_sync);
  assign push_full  = (push_slots == '0);

  // One credit per cycle, held back by the stall and before the first cycle out of reset
  assign push_credit = credit_active && (credit_pend != '0) && !push_credit_stall;

  always_ff @(posedge push_clk) begin
    if (!rst_sync_n) begin
      push_count      <= '0;
      push_count_gray <= '0;
      pop_count_seen  <= '0;
      credit_pend     <= CountWidth'(Depth);
      credit_active   <= 1'b0;
    end else begin
      credit_active <= 1'b1;
      if (push_valid) begin
        push_count <= push_count + 1'b1;
      end
      // Taken from the updated count one cycle after the RAM write
      push_count_gray <= CountWidth'(cdc_fifo_pkg::bin_to_gray(32'(push_count)));
      pop_count_seen  <= pop_count_sync;
      credit_pend     <= credit_pend + slots_freed - CountWidth'(push_credit);
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Credits the sender holds, from the invariant pend + held + stored == Depth
  assign credit_out = CountWidth'(Depth) - credit_pend - (push_count - pop_count_seen);

  a_push_with_credit : assert property (@(posedge push_clk) disable iff (!rst_sync_n)
    push_valid |-> (credit_out != '0));

  a_no_push_when_full : assert property (@(posedge push_clk) disable iff (!rst_sync_n)
    push_valid |-> !push_full);

endmodule : cdc_fifo_push_ctrl

`default_nettype wire

// File: cdc_gray_sync.sv
// Gray count synchronizer
`default_nettype none

module cdc_gray_sync #(
    parameter int Depth = 8,
    parameter int NumSyncStages = 3,
    localparam int CountWidth = $clog2(Depth + 1)
) (
    // Destination clock and its synchronized reset
    input  logic                  clk,
    input  logic                  rst_n,
    // Gray count from a register in the source domain
    input  logic [CountWidth-1:0] gray_in,
    output logic [CountWidth-1:0] gray_out
);

  // Only one bit of gray_in moves per source update, so any stage can
  // resolve to either the old or the new count and never to a third value
  logic [CountWidth-1:0] sync_q [NumSyncStages];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NumSyncStages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      for (int i = 1; i < NumSyncStages; i++) begin
        sync_q[i] <= sync_q[i - 1];
      end
    end
  end

  assign gray_out = sync_q[NumSyncStages-1];

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  logic [CountWidth-1:0] gray_in_bin;

  assign gray_in_bin = CountWidth'(cdc_fifo_pkg::gray_to_bin(32'(gray_in)));

  // Every pattern decodes to some count, so a bad update shows up as a jump
  // A faster source may step several times between two samples, never past Depth
  // A count that runs backward wraps to a distance above Depth
  a_bounded_step : assert property (@(posedge clk) disable iff (!rst_n)
    CountWidth'(gray_in_bin - $past(gray_in_bin)) <= CountWidth'(Depth));

endmodule : cdc_gray_sync

`default_nettype wire

// File: cdc_fifo_pkg.sv
// CDC FIFO shared definitions
`default_nettype none

package cdc_fifo_pkg;

  // --------------------------------------------------
  // Default sizes
  // --------------------------------------------------

  // Number of FIFO entries, which must be a power of two
  localparam int default_depth = 8;
  // Bits per FIFO word
  localparam int default_width = 16;
  // Flops in each Gray count synchronizer
  localparam int default_sync_stages = 3;

  // --------------------------------------------------
  // Pop-side staging buffer states
  // --------------------------------------------------

  typedef enum logic [1:0] {
    STAGE_EMPTY    = 2'd0,
    STAGE_WAIT_RAM = 2'd1,
    STAGE_FULL     = 2'd2
  } stage_state_e;

  // --------------------------------------------------
  // Gray code conversion
  // --------------------------------------------------

  // Counts of CountWidth bits are zero extended to 32 bits on the way in
  // Leading zeros stay zero in both directions, so callers keep the low bits
  function automatic logic [31:0] bin_to_gray(input logic [31:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [31:0] gray_to_bin(input logic [31:0] gray);
    logic [31:0] bin;
    bin[31] = gray[31];
    // Each binary bit is the XOR of all Gray bits at and above it
    for (int i = 30; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : cdc_fifo_pkg

`default_nettype wire
